// ==== hdl/sdramPkg.sv ====
package sdramPkg;

    // Timing in 10 ns clock cycles.
    localparam int tPowerUp = 20000;        // 200 us of NOP after reset.
    localparam int tRp = 5;                 // Precharge time.
    localparam int tRc = 13;                // Refresh cycle time.
    localparam int tMrd = 5;                // Mode register set time.
    localparam int tRcd = 3;                // Activate to read or write.
    localparam int tDpl = 3;                // Write recovery.
    localparam int casLatency = 2;
    localparam int initRefreshes = 2;
    localparam int autoRefreshes = 2;

    // Widths.
    localparam int bankW = 2;
    localparam int rowW = 12;
    localparam int colW = 8;
    localparam int dataW = 32;
    localparam int reqAddrW = bankW + rowW + colW;  // Bank, row, column.
    localparam int addrPinW = 12;
    localparam int cmdW = 4;                // CS, RAS, CAS, WE. All active low.
    localparam int opW = 2;
    localparam int selW = 2;
    localparam int timerW = 15;             // Holds tPowerUp.
    localparam int stateW = 3;

    // Command pin patterns.
    localparam logic [cmdW-1:0] cmdNop = 4'b0111;
    localparam logic [cmdW-1:0] cmdPall = 4'b0010;
    localparam logic [cmdW-1:0] cmdRef = 4'b0001;
    localparam logic [cmdW-1:0] cmdMrs = 4'b0000;
    localparam logic [cmdW-1:0] cmdAct = 4'b0011;
    localparam logic [cmdW-1:0] cmdRead = 4'b0101;
    localparam logic [cmdW-1:0] cmdWrite = 4'b0100;

    // Operation codes.
    localparam logic [opW-1:0] opInit = 2'd0;
    localparam logic [opW-1:0] opRefresh = 2'd1;
    localparam logic [opW-1:0] opRead = 2'd2;
    localparam logic [opW-1:0] opWrite = 2'd3;

    // Address pin source.
    localparam logic [selW-1:0] selRow = 2'd0;
    localparam logic [selW-1:0] selCol = 2'd1;
    localparam logic [selW-1:0] selMode = 2'd2;
    localparam logic [selW-1:0] selAll = 2'd3;     // A10 high for precharge-all.

    // Sequencer steps. Each one waits after the command that entered it.
    localparam logic [stateW-1:0] stIdle = 3'd0;
    localparam logic [stateW-1:0] stPowerUp = 3'd1;
    localparam logic [stateW-1:0] stPall = 3'd2;
    localparam logic [stateW-1:0] stRef = 3'd3;
    localparam logic [stateW-1:0] stMrs = 3'd4;
    localparam logic [stateW-1:0] stAct = 3'd5;
    localparam logic [stateW-1:0] stAccess = 3'd6;

    // Mode register fields.
    localparam logic [2:0] modeBurstLen = 3'd0;    // Burst of one.
    localparam logic modeBurstType = 1'b0;         // Sequential.
    localparam logic [2:0] modeCas = 3'(casLatency);
    localparam logic [1:0] modeOpMode = 2'd0;      // Standard operation.
    localparam logic modeWriteBurst = 1'b0;        // Writes follow burst length.

    // One address pin word, three meanings.
    typedef union packed {
        logic [rowW-1:0] rowView;
        struct packed {
            logic spareHi;                        // A11.
            logic autoPre;                        // A10.
            logic [addrPinW-colW-3:0] spareLo;    // A9..A8.
            logic [colW-1:0] col;
        } colView;
        struct packed {
            logic [1:0] reserved;                 // A11..A10, kept zero.
            logic writeBurst;
            logic [1:0] opMode;
            logic [2:0] casLat;
            logic burstType;
            logic [2:0] burstLen;
        } modeView;
    } addrPinU;

endpackage

// ==== hdl/waitTimer.sv ====
module waitTimer (
    input  logic iClk,
    input  logic iRst_N,
    input  logic load_i,
    input  logic [sdramPkg::timerW-1:0] count_i,
    output logic expired_o
);
    import sdramPkg::*;

    logic [timerW-1:0] cnt;     // Cycles left, zero when idle.

    always_ff @(posedge iClk or negedge iRst_N)
    begin
        if (!iRst_N)
            cnt <= '0;
        else if (load_i)
            cnt <= count_i;     // Reload wins over countdown.
        else if (cnt != '0)
            cnt <= cnt - 1'b1;
    end

    // Last cycle of the wait.
    assign expired_o = (cnt == timerW'(1));

endmodule

// ==== hdl/cmdAddrGen.sv ====
module cmdAddrGen (
    input  logic iClk,
    input  logic iRst_N,
    input  logic accept_i,
    input  logic [sdramPkg::reqAddrW-1:0] reqAddr_i,
    input  logic [sdramPkg::cmdW-1:0] cmd_i,
    input  logic [sdramPkg::selW-1:0] addrSel_i,
    output logic [sdramPkg::cmdW-1:0] ramCmd_o,
    output logic [sdramPkg::bankW-1:0] ramBank_o,
    output logic [sdramPkg::addrPinW-1:0] ramAddr_o
);
    import sdramPkg::*;

    logic [reqAddrW-1:0] addrQ;     // Held request address.
    logic [reqAddrW-1:0] curAddr;
    logic [bankW-1:0] bankNext;
    addrPinU addrWord;

    // ACT goes out in the accept cycle itself.
    assign curAddr = accept_i ? reqAddr_i : addrQ;

    always_ff @(posedge iClk)
    begin
        if (accept_i)
            addrQ <= reqAddr_i;
    end

    always_comb
    begin
        addrWord = '1;          // Precharge-all, A10 high.
        case (addrSel_i)
            selRow:
                addrWord.rowView = curAddr[colW +: rowW];
            selCol:
            begin
                addrWord = '0;
                addrWord.colView.autoPre = 1'b1;    // Auto precharge.
                addrWord.colView.col = curAddr[colW-1:0];
            end
            selMode:
            begin
                addrWord.modeView.reserved = '0;
                addrWord.modeView.writeBurst = modeWriteBurst;
                addrWord.modeView.opMode = modeOpMode;
                addrWord.modeView.casLat = modeCas;
                addrWord.modeView.burstType = modeBurstType;
                addrWord.modeView.burstLen = modeBurstLen;
            end
            default:
                addrWord.rowView = '1;
        endcase
    end

    assign bankNext = (addrSel_i == selMode) ? '0 : curAddr[reqAddrW-1 -: bankW];

    always_ff @(posedge iClk or negedge iRst_N)
    begin
        if (!iRst_N)
        begin
            ramCmd_o <= cmdNop;
            ramBank_o <= '1;
            ramAddr_o <= '1;
        end
        else
        begin
            ramCmd_o <= cmd_i;      // Pins trail the sequencer by one cycle.
            ramBank_o <= bankNext;
            ramAddr_o <= addrWord;
        end
    end

endmodule

// ==== hdl/dqPath.sv ====
module dqPath (
    input  logic iClk,
    input  logic iRst_N,
    input  logic accept_i,
    input  logic [sdramPkg::dataW-1:0] wrData_i,
    input  logic dqOe_i,
    input  logic dqmOn_i,
    input  logic rdCapture_i,
    output logic [sdramPkg::dataW/8-1:0] ramDqm_o,
    inout  wire  [sdramPkg::dataW-1:0] ramDq_io,
    output logic [sdramPkg::dataW-1:0] rdData_o
);
    import sdramPkg::*;

    logic [dataW-1:0] wrQ;      // Accepted write word.
    logic oeQ;                  // Bus drive, aligned to the pins.

    always_ff @(posedge iClk)
    begin
        if (accept_i)
            wrQ <= wrData_i;
        if (rdCapture_i)
            rdData_o <= ramDq_io;   // Held until the next read.
    end

    // Registered like the command so both reach the pins together.
    always_ff @(posedge iClk or negedge iRst_N)
    begin
        if (!iRst_N)
        begin
            oeQ <= 1'b0;
            ramDqm_o <= '1;         // All bytes masked.
        end
        else
        begin
            oeQ <= dqOe_i;
            ramDqm_o <= dqmOn_i ? '0 : '1;
        end
    end

    assign ramDq_io = oeQ ? wrQ : 'z;

endmodule

// ==== hdl/opSequencer.sv ====
module opSequencer (
    input  logic iClk,
    input  logic iRst_N,
    input  logic opStart_i,
    input  logic [sdramPkg::opW-1:0] opCode_i,
    output logic accept_o,
    output logic [sdramPkg::cmdW-1:0] cmd_o,
    output logic [sdramPkg::selW-1:0] addrSel_o,
    output logic load_o,
    output logic [sdramPkg::timerW-1:0] count_o,
    input  logic expired_i,
    output logic dqOe_o,
    output logic dqmOn_o,
    output logic rdCapture_o,
    output logic opDone_o
);
    import sdramPkg::*;

    logic [stateW-1:0] step;
    logic [stateW-1:0] stepNext;
    logic [opW-1:0] opQ;            // Operation in flight.
    logic initDone;
    logic [1:0] refLeft;            // Refreshes still to issue.
    logic finish;
    logic rdIssue;
    logic [casLatency:0] rdPipe;    // READ issue delayed to the data cycle.

    always_comb
    begin
        cmd_o = cmdNop;
        addrSel_o = selAll;
        load_o = 1'b0;
        count_o = '0;
        accept_o = 1'b0;
        dqOe_o = 1'b0;
        dqmOn_o = 1'b0;
        finish = 1'b0;
        stepNext = step;
        case (step)
            stIdle:
                if (!initDone)
                begin
                    load_o = 1'b1;      // Power-up wait, NOP on the pins.
                    count_o = timerW'(tPowerUp);
                    stepNext = stPowerUp;
                end
                else if (opStart_i)
                begin
                    accept_o = 1'b1;
                    load_o = 1'b1;
                    if (opCode_i == opRead || opCode_i == opWrite)
                    begin
                        cmd_o = cmdAct;
                        addrSel_o = selRow;
                        count_o = timerW'(tRcd);
                        stepNext = stAct;
                    end
                    else
                    begin
                        cmd_o = cmdPall;    // Init or refresh.
                        count_o = timerW'(tRp);
                        stepNext = stPall;
                    end
                end
            stPowerUp:
                if (expired_i)
                begin
                    cmd_o = cmdPall;
                    load_o = 1'b1;
                    count_o = timerW'(tRp);
                    stepNext = stPall;
                end
            stPall:
                if (expired_i)
                begin
                    cmd_o = cmdRef;
                    load_o = 1'b1;
                    count_o = timerW'(tRc);
                    stepNext = stRef;
                end
            stRef:
                if (expired_i)
                begin
                    if (refLeft != '0)
                    begin
                        cmd_o = cmdRef;     // Another refresh.
                        load_o = 1'b1;
                        count_o = timerW'(tRc);
                    end
                    else if (opQ == opInit)
                    begin
                        cmd_o = cmdMrs;
                        addrSel_o = selMode;
                        load_o = 1'b1;
                        count_o = timerW'(tMrd);
                        stepNext = stMrs;
                    end
                    else
                    begin
                        finish = 1'b1;
                        stepNext = stIdle;
                    end
                end
            stMrs:
                if (expired_i)
                begin
                    finish = 1'b1;
                    stepNext = stIdle;
                end
            stAct:
                if (expired_i)
                begin
                    addrSel_o = selCol;
                    load_o = 1'b1;
                    dqmOn_o = 1'b1;
                    if (opQ == opWrite)
                    begin
                        cmd_o = cmdWrite;
                        dqOe_o = 1'b1;      // Data rides with the command.
                        count_o = timerW'(tDpl + tRp);
                    end
                    else
                    begin
                        cmd_o = cmdRead;
                        count_o = timerW'(casLatency + tRp);
                    end
                    stepNext = stAccess;
                end
            stAccess:
            begin
                dqmOn_o = 1'b1;
                dqOe_o = (opQ == opWrite);
                if (expired_i)
                begin
                    finish = 1'b1;
                    stepNext = stIdle;
                end
            end
            default:
                stepNext = stIdle;
        endcase
    end

    assign rdIssue = (step == stAct) && expired_i && (opQ == opRead);
    assign rdCapture_o = rdPipe[casLatency];

    always_ff @(posedge iClk or negedge iRst_N)
    begin
        if (!iRst_N)
        begin
            step <= stIdle;
            opQ <= opInit;
            initDone <= 1'b0;
            refLeft <= '0;
            rdPipe <= '0;
            opDone_o <= 1'b0;
        end
        else
        begin
            step <= stepNext;
            opDone_o <= finish;     // One-cycle pulse.
            rdPipe <= {rdPipe[casLatency-1:0], rdIssue};
            if (accept_o)
                opQ <= opCode_i;
            if (finish && opQ == opInit)
                initDone <= 1'b1;
            // Count the refreshes left after the first REF.
            if (step == stPall && expired_i)
                refLeft <= (opQ == opInit) ? 2'(initRefreshes - 1) : 2'(autoRefreshes - 1);
            else if (step == stRef && expired_i && refLeft != '0)
                refLeft <= refLeft - 1'b1;
        end
    end

endmodule

// ==== hdl/sdramCtrl.sv ====
module sdramCtrl (
    input  logic iClk,
    input  logic iRst_N,
    input  logic opStart_i,
    input  logic [sdramPkg::opW-1:0] opCode_i,
    input  logic [sdramPkg::reqAddrW-1:0] reqAddr_i,
    input  logic [sdramPkg::dataW-1:0] wrData_i,
    output logic opDone_o,
    output logic [sdramPkg::dataW-1:0] rdData_o,
    output logic [sdramPkg::cmdW-1:0] ramCmd_o,
    output logic [sdramPkg::bankW-1:0] ramBank_o,
    output logic [sdramPkg::addrPinW-1:0] ramAddr_o,
    output logic [sdramPkg::dataW/8-1:0] ramDqm_o,
    inout  wire  [sdramPkg::dataW-1:0] ramDq_io
);
    import sdramPkg::*;

    logic accept;
    logic [cmdW-1:0] cmd;
    logic [selW-1:0] addrSel;
    logic load;
    logic [timerW-1:0] count;
    logic expired;
    logic dqOe;
    logic dqmOn;
    logic rdCapture;

    // Control FSM.
    opSequencer uSeq (
        .iClk(iClk),
        .iRst_N(iRst_N),
        .opStart_i(opStart_i),
        .opCode_i(opCode_i),
        .accept_o(accept),
        .cmd_o(cmd),
        .addrSel_o(addrSel),
        .load_o(load),
        .count_o(count),
        .expired_i(expired),
        .dqOe_o(dqOe),
        .dqmOn_o(dqmOn),
        .rdCapture_o(rdCapture),
        .opDone_o(opDone_o)
    );

    waitTimer uTimer (
        .iClk(iClk),
        .iRst_N(iRst_N),
        .load_i(load),
        .count_i(count),
        .expired_o(expired)
    );

    // Command, bank and address pins.
    cmdAddrGen uCmdAddr (
        .iClk(iClk),
        .iRst_N(iRst_N),
        .accept_i(accept),
        .reqAddr_i(reqAddr_i),
        .cmd_i(cmd),
        .addrSel_i(addrSel),
        .ramCmd_o(ramCmd_o),
        .ramBank_o(ramBank_o),
        .ramAddr_o(ramAddr_o)
    );

    dqPath uDq (
        .iClk(iClk),
        .iRst_N(iRst_N),
        .accept_i(accept),
        .wrData_i(wrData_i),
        .dqOe_i(dqOe),
        .dqmOn_i(dqmOn),
        .rdCapture_i(rdCapture),
        .ramDqm_o(ramDqm_o),
        .ramDq_io(ramDq_io),
        .rdData_o(rdData_o)
    );

endmodule

// ==== verif/sdramModel.sv ====
module sdramModel (
    input  logic iClk,
    input  logic [sdramPkg::cmdW-1:0] cmd_i,
    input  logic [sdramPkg::bankW-1:0] bank_i,
    input  logic [sdramPkg::addrPinW-1:0] addr_i,
    input  logic [sdramPkg::dataW/8-1:0] dqm_i,
    inout  wire  [sdramPkg::dataW-1:0] dq_io
);
    import sdramPkg::*;

    logic [dataW-1:0] mem [logic [reqAddrW-1:0]];   // Sparse cell store.
    logic [rowW-1:0] openRow [1 << bankW];          // Row opened by the last ACT.
    logic [casLatency-1:0] rdStage = '0;            // READ seen, one bit per cycle.
    logic [dataW-1:0] rdWord = '0;
    logic [reqAddrW-1:0] cellAddr;

    // Bank, open row and column pins name one cell.
    assign cellAddr = {bank_i, openRow[bank_i], addr_i[colW-1:0]};

    // Unwritten cells read back a pattern tied to the full address.
    function automatic logic [dataW-1:0] fillWord(input logic [reqAddrW-1:0] a);
        return {~a[dataW-reqAddrW-1:0], a};
    endfunction

    always @(posedge iClk)
    begin
        rdStage <= {rdStage[casLatency-2:0], cmd_i == cmdRead};
        case (cmd_i)
            cmdAct:
                openRow[bank_i] <= addr_i;      // Row address on all pins.
            cmdWrite:
                if (dqm_i == '0)
                    mem[cellAddr] = dq_io;      // Data rides with the command.
            cmdRead:
                rdWord <= mem.exists(cellAddr) ? mem[cellAddr] : fillWord(cellAddr);
            default:
                ;
        endcase
    end

    // Driven only in the one cycle that ends at the CAS edge.
    assign dq_io = rdStage[casLatency-1] ? rdWord : 'z;

endmodule

// ==== verif/sdramTb.sv ====
module sdramTb;
    import sdramPkg::*;

    localparam int numOps = 40;
    localparam int longestOp = tRp + autoRefreshes * tRc + 12;  // Refresh plus request overhead.
    localparam int initLen = 8 + tPowerUp + tRp + initRefreshes * tRc + tMrd;
    localparam int cycleLimit = initLen + numOps * longestOp + 500;

    logic iClk = 1'b0;
    logic iRst_N;
    logic opStart;
    logic [opW-1:0] opCode;
    logic [reqAddrW-1:0] reqAddr;
    logic [dataW-1:0] wrData;
    logic opDone;
    logic [dataW-1:0] rdData;
    logic [cmdW-1:0] ramCmd;
    logic [bankW-1:0] ramBank;
    logic [addrPinW-1:0] ramAddr;
    logic [dataW/8-1:0] ramDqm;
    wire  [dataW-1:0] ramDq;

    integer seed;
    int opErrs;                     // Failures seen by the stimulus thread.
    int monErrs = 0;                // Failures seen by the pin monitor.
    int cycles = 0;                 // Timeout counter.
    int monCyc = 0;                 // Cycles since reset release.
    int doneCnt = 0;
    logic doneLast = 1'b0;
    logic seenCmd = 1'b0;
    int lastCyc = 0;
    logic [cmdW-1:0] lastCmd = cmdNop;
    logic [cmdW-1:0] cmdQ[$];       // Every non-NOP pin command, in order.
    logic [bankW-1:0] bankQ[$];
    logic [addrPinW-1:0] addrQ[$];
    logic [dataW-1:0] refMem [logic [reqAddrW-1:0]];
    logic [reqAddrW-1:0] written[$];

    sdramCtrl uut (
        .iClk(iClk),
        .iRst_N(iRst_N),
        .opStart_i(opStart),
        .opCode_i(opCode),
        .reqAddr_i(reqAddr),
        .wrData_i(wrData),
        .opDone_o(opDone),
        .rdData_o(rdData),
        .ramCmd_o(ramCmd),
        .ramBank_o(ramBank),
        .ramAddr_o(ramAddr),
        .ramDqm_o(ramDqm),
        .ramDq_io(ramDq)
    );

    sdramModel uMem (
        .iClk(iClk),
        .cmd_i(ramCmd),
        .bank_i(ramBank),
        .addr_i(ramAddr),
        .dqm_i(ramDqm),
        .dq_io(ramDq)
    );

    always #10 iClk = ~iClk;

    // Minimum pin gap after each command.
    function automatic int minGap(input logic [cmdW-1:0] cmd);
        case (cmd)
            cmdPall:  return tRp;
            cmdRef:   return tRc;
            cmdMrs:   return tMrd;
            cmdAct:   return tRcd;
            cmdWrite: return tDpl + tRp;
            cmdRead:  return casLatency + tRp;
            default:  return 1;
        endcase
    endfunction

    // Pins are sampled at the falling edge, away from the register updates.
    always @(negedge iClk)
    begin
        if (iRst_N)
        begin
            monCyc++;
            if (opDone)
            begin
                doneCnt++;
                assert (!doneLast) else
                begin
                    monErrs++;
                    $display("ERR %0t: opDone_o high for more than one cycle", $time);
                end
            end
            doneLast = opDone;
            if (ramCmd != cmdNop)
            begin
                if (!seenCmd)
                begin
                    assert (monCyc >= tPowerUp) else
                    begin
                        monErrs++;
                        $display("ERR %0t: first command after %0d cycles", $time, monCyc);
                    end
                end
                else
                begin
                    assert (monCyc - lastCyc >= minGap(lastCmd)) else
                    begin
                        monErrs++;
                        $display("ERR %0t: cmd %b only %0d cycles after cmd %b", $time,
                            ramCmd, monCyc - lastCyc, lastCmd);
                    end
                end
                seenCmd = 1'b1;
                lastCyc = monCyc;
                lastCmd = ramCmd;
                cmdQ.push_back(ramCmd);
                bankQ.push_back(ramBank);
                addrQ.push_back(ramAddr);
            end
        end
    end

    always @(posedge iClk)
    begin
        cycles++;
        if (cycles >= cycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Errors: %0d, timeouts: 1, cycles: %0d", opErrs + monErrs, cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic expectCmd(input int idx, input logic [cmdW-1:0] cmd, input logic useBank,
        input logic [bankW-1:0] bank, input logic [addrPinW-1:0] mask,
        input logic [addrPinW-1:0] value);
        assert (cmdQ[idx] == cmd && (!useBank || bankQ[idx] == bank)
            && (addrQ[idx] & mask) == value) else
        begin
            opErrs++;
            $display("ERR %0t: got cmd %b bank %0d addr %h, expected cmd %b bank %0d addr %h",
                $time, cmdQ[idx], bankQ[idx], addrQ[idx], cmd, bank, value);
        end
    endtask

    // Pin commands and done pulses of one finished operation.
    task automatic checkOp(input logic [opW-1:0] op, input logic [reqAddrW-1:0] addr,
        input int base, input int startDone);
        int n;
        logic [bankW-1:0] bank;
        logic [colW-1:0] col;
        bank = addr[reqAddrW-1 -: bankW];
        col = addr[colW-1:0];
        n = (op == opInit) ? 2 + initRefreshes : (op == opRefresh) ? 1 + autoRefreshes : 2;
        assert (doneCnt - startDone == 1) else
        begin
            opErrs++;
            $display("ERR %0t: %0d done pulses for op %0d", $time, doneCnt - startDone, op);
        end
        assert (cmdQ.size() - base == n) else
        begin
            opErrs++;
            $display("ERR %0t: %0d commands for op %0d, expected %0d", $time,
                cmdQ.size() - base, op, n);
        end
        if (cmdQ.size() - base == n)
        begin
            if (op == opInit || op == opRefresh)
            begin
                expectCmd(base, cmdPall, 1'b0, '0, 12'h400, 12'h400);  // A10 selects all banks.
                for (int i = 1; i < n - (op == opInit ? 1 : 0); i++)
                    expectCmd(base + i, cmdRef, 1'b0, '0, '0, '0);
                if (op == opInit)
                    expectCmd(base + n - 1, cmdMrs, 1'b1, '0, '1,
                        {2'b00, 1'b0, 2'b00, 3'(casLatency), 1'b0, 3'b000});
            end
            else
            begin
                expectCmd(base, cmdAct, 1'b1, bank, '1, addr[colW +: rowW]);
                expectCmd(base + 1, (op == opWrite) ? cmdWrite : cmdRead, 1'b1, bank,
                    12'h4ff, {1'b0, 1'b1, 2'b00, col});     // Auto precharge set.
            end
        end
    endtask

    task automatic runOp(input logic [opW-1:0] op, input logic [reqAddrW-1:0] addr,
        input logic [dataW-1:0] data, input logic extra);
        int base;
        int startDone;
        logic [dataW-1:0] expWord;
        base = cmdQ.size();
        startDone = doneCnt;
        expWord = refMem.exists(addr) ? refMem[addr] : '0;
        @(posedge iClk);
        opStart <= 1'b1;
        opCode <= op;
        reqAddr <= addr;
        wrData <= data;
        @(posedge iClk);
        opStart <= 1'b0;
        if (extra)
        begin
            @(posedge iClk);
            opStart <= 1'b1;                // Busy now, must be dropped.
            opCode <= opW'($random(seed));
            reqAddr <= reqAddrW'($random(seed));
            wrData <= $random(seed);
            @(posedge iClk);
            opStart <= 1'b0;
        end
        @(negedge iClk);
        while (!opDone)
            @(negedge iClk);
        if (op == opRead)
        begin
            assert (rdData == expWord) else
            begin
                opErrs++;
                $display("ERR %0t: read at %h gave %h, expected %h", $time, addr, rdData, expWord);
            end
        end
        if (op == opWrite)
        begin
            if (!refMem.exists(addr))
                written.push_back(addr);
            refMem[addr] = data;
        end
        @(posedge iClk);
        @(posedge iClk);
        checkOp(op, addr, base, startDone);
    endtask

    initial
    begin
        int kind;
        logic [reqAddrW-1:0] addr;
        iRst_N = 1'b0;
        opStart = 1'b0;
        opCode = opInit;
        reqAddr = '0;
        wrData = '0;
        opErrs = 0;
        seed = 32'h0b726a5f;
        repeat (8) @(posedge iClk);
        iRst_N <= 1'b1;
        @(negedge iClk);
        while (!opDone)                     // Init starts on its own.
            @(negedge iClk);
        @(posedge iClk);
        @(posedge iClk);
        checkOp(opInit, '0, 0, 0);
        for (int i = 0; i < numOps; i++)
        begin
            kind = $unsigned($random(seed)) % 8;
            if (written.size() == 0 || kind < 3)
            begin
                addr = reqAddrW'($random(seed));
                runOp(opWrite, addr, $random(seed), ($unsigned($random(seed)) % 4) == 0);
            end
            else if (kind < 7)
            begin
                addr = written[$unsigned($random(seed)) % written.size()];
                runOp(opRead, addr, '0, ($unsigned($random(seed)) % 4) == 0);
            end
            else
                runOp(opRefresh, '0, '0, ($unsigned($random(seed)) % 4) == 0);
        end
        $display("Errors: %0d, timeouts: 0, cycles: %0d", opErrs + monErrs, cycles);
        if (opErrs + monErrs == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== tb.f ====
hdl/sdramPkg.sv
hdl/waitTimer.sv
hdl/cmdAddrGen.sv
hdl/dqPath.sv
hdl/opSequencer.sv
hdl/sdramCtrl.sv
verif/sdramModel.sv
verif/sdramTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the SDRAM controller testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module sdramTb -f tb.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out="$(./obj_dir/simv)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
